// ==== Makefile ====
# Verilator build and run for the 16-bit multicycle core

VERILATOR ?= verilator
TOP       ?= tb_core
RTL_TOP   ?= vmicro_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
src/isa_pkg.sv
src/soc_pkg.sv
src/block_ram.sv
src/instr_decoder.sv
src/alu.sv
src/core_mmu.sv
src/vmicro_core.sv
verif/tb_core.sv

// ==== src/alu.sv ====
// Combinational ALU
// Pass-through, bitwise, shift, add, subtract and compare
`timescale 1ns/10ps

module alu import isa_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   c
);

    always_comb begin
        c = '0;
        case (op)
            // Moves and memory ops forward the second operand
            ALU_LW,
            ALU_SW,
            ALU_MOV,
            ALU_MOVI:  c = b;

            ALU_OR:    c = a | b;
            ALU_XOR:   c = a ^ b;
            ALU_AND:   c = a & b;
            ALU_NOT:   c = ~b;
            ALU_LSHFT: c = a << b;
            ALU_RSHFT: c = a >> b;

            ALU_UADD,
            ALU_UADDI: c = a + b;
            ALU_USUB:  c = a - b;

            // Only the flag bits are set, rest stay zero
            ALU_CMP: begin
                c[FLAG_Z] = (a == b);
                c[FLAG_L] = (a < b);
            end

            // NOP and branch produce nothing
            default:   c = '0;
        endcase
    end

endmodule

// ==== src/block_ram.sv ====
// Single-port synchronous block RAM
// A write updates the cell, otherwise the addressed word is registered out
`timescale 1ns/10ps

module block_ram import isa_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_t                    wdata,
    input  logic                     we,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

    // Depth need not be a power of two
    assert property (@(posedge clk) int'(addr) < DEPTH)
        else $error("block_ram address beyond depth");

endmodule

// ==== src/core_mmu.sv ====
// Core memory unit
// Scratch RAM for the low window, APB master transfer for everything else
`timescale 1ns/10ps

module core_mmu import isa_pkg::*, soc_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    output logic     busy,
    input  word_t    addr,
    input  word_t    wdata,
    input  logic     we,
    output word_t    rdata,
    output apb_req_t apb_req,
    input  apb_rsp_t apb_rsp
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

    apb_state_e state;
    word_t      apb_rdata;
    word_t      scratch_rdata;
    logic       in_window;

    assign in_window = (addr <= SCRATCH_END);
    assign busy      = req || (state != IDLE);
    assign rdata     = in_window ? scratch_rdata : apb_rdata;

    block_ram #(
        .DEPTH (SCRATCH_DEPTH)
    ) u_scratch (
        .clk   (clk),
        .addr  (addr[$bits(scratch_addr_t)-1:0]),
        .wdata (wdata),
        .we    (req && we && in_window),
        .rdata (scratch_rdata)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            apb_req <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req && !in_window) begin
                        apb_req.paddr  <= addr;
                        apb_req.pwdata <= wdata;
                        apb_req.pwrite <= we;
                        apb_req.psel   <= 1'b1;
                        state          <= SETUP;
                    end
                end
                SETUP: begin
                    apb_req.penable <= 1'b1;
                    state           <= ACCESS;
                end
                ACCESS: begin
                    // Slave stretches the access with pready low
                    if (apb_rsp.pready) begin
                        apb_req.psel    <= 1'b0;
                        apb_req.penable <= 1'b0;
                        apb_req.pwrite  <= 1'b0;
                        state           <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ACCESS && apb_rsp.pready) begin
            apb_rdata <= apb_rsp.prdata;
        end
    end

    // Selected until the slave completes the access phase
    assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> apb_req.psel);

    // Access phase always follows a setup cycle
    assert property (@(posedge clk) disable iff (reset)
        $rose(apb_req.penable) |-> $past(apb_req.psel));

endmodule

// ==== src/instr_decoder.sv ====
// Instruction decoder
// Splits an instruction word into fields, ALU operation and control flags
`timescale 1ns/10ps

module instr_decoder import isa_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    always_comb begin
        dec        = '0;
        dec.rd     = instr[10:8];
        dec.ra     = instr[7:5];
        dec.imm4   = instr[3:0];
        dec.imm8   = instr[7:0];
        dec.simm5  = instr[4:0];
        dec.alu_op = ALU_NOP;

        case (opcode_e'(instr[15:11]))
            OP_LW: begin
                dec.alu_op  = ALU_LW;
                dec.has_we  = 1'b1;
                dec.has_mem = 1'b1;
            end
            OP_SW: begin
                dec.alu_op     = ALU_SW;
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            OP_MOV: begin
                dec.alu_op = ALU_MOV;
                dec.has_we = 1'b1;
            end
            OP_MOVI: begin
                dec.alu_op   = ALU_MOVI;
                dec.has_we   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            OP_BIT: begin
                dec.has_we = 1'b1;
                case (instr[4:0])
                    BIT_OR:    dec.alu_op = ALU_OR;
                    BIT_XOR:   dec.alu_op = ALU_XOR;
                    BIT_AND:   dec.alu_op = ALU_AND;
                    BIT_NOT:   dec.alu_op = ALU_NOT;
                    BIT_LSHFT: dec.alu_op = ALU_LSHFT;
                    BIT_RSHFT: dec.alu_op = ALU_RSHFT;
                    default:   dec.has_we = 1'b0;
                endcase
            end
            OP_ARITH_U: begin
                dec.has_we = 1'b1;
                // Immediate form only looks at the top sub-function bit
                if (instr[4] == ARITH_UADDI[4]) begin
                    dec.alu_op   = ALU_UADDI;
                    dec.has_imm4 = 1'b1;
                end else if (instr[4:0] == ARITH_UADD) begin
                    dec.alu_op = ALU_UADD;
                end else if (instr[4:0] == ARITH_USUB) begin
                    dec.alu_op = ALU_USUB;
                end else begin
                    dec.has_we = 1'b0;
                end
            end
            OP_BR: begin
                dec.alu_op   = ALU_BR;
                dec.has_br   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            OP_CMP: begin
                dec.alu_op  = ALU_CMP;
                dec.has_cmp = 1'b1;
            end
            // NOP and anything unrecognised do nothing
            default: dec.alu_op = ALU_NOP;
        endcase
    end

endmodule

// ==== src/isa_pkg.sv ====
// Instruction set definitions for the 16-bit multicycle core
// Word and register types, opcodes, ALU operations, decode bundle
package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;

    localparam int NUM_REGS = 8;

    // Major opcodes, instr[15:11]
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h06,
        OP_BR      = 5'h08,
        OP_CMP     = 5'h09
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_LW, ALU_SW, ALU_MOV, ALU_MOVI, ALU_BR,
        ALU_OR, ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT, ALU_RSHFT,
        ALU_UADD, ALU_USUB, ALU_UADDI, ALU_CMP
    } alu_op_e;

    // Bitwise group sub-functions, instr[4:0]
    localparam logic [4:0] BIT_OR    = 5'b00000;
    localparam logic [4:0] BIT_XOR   = 5'b00001;
    localparam logic [4:0] BIT_AND   = 5'b00010;
    localparam logic [4:0] BIT_NOT   = 5'b00011;
    localparam logic [4:0] BIT_LSHFT = 5'b00100;
    localparam logic [4:0] BIT_RSHFT = 5'b00101;

    // Arithmetic group; any code with bit 4 clear is the imm4 add
    localparam logic [4:0] ARITH_UADD  = 5'b11111;
    localparam logic [4:0] ARITH_USUB  = 5'b10000;
    localparam logic [4:0] ARITH_UADDI = 5'b00000;

    // Branch conditions carried in imm8
    localparam logic [7:0] BR_U = 8'h00;
    localparam logic [7:0] BR_E = 8'h01;
    localparam logic [7:0] BR_L = 8'h05;

    // Compare result bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_L = 1;

    typedef struct packed {
        reg_sel_t   rd;
        reg_sel_t   ra;
        logic [3:0] imm4;
        logic [7:0] imm8;
        logic [4:0] simm5;
        alu_op_e    alu_op;
        logic       has_imm4;
        logic       has_imm8;
        logic       has_we;
        logic       has_br;
        logic       has_mem;
        logic       has_mem_we;
        logic       has_cmp;
    } decoded_t;

endpackage

// ==== src/soc_pkg.sv ====
// Bus and memory map definitions
// APB master bundles, memory depths and the scratch window
package soc_pkg;
    import isa_pkg::*;

    localparam int INSTR_DEPTH   = 64;
    localparam int SCRATCH_DEPTH = 64;

    // Scratch window starts at address 0
    localparam word_t SCRATCH_END = 16'h003F;

    typedef logic [$clog2(INSTR_DEPTH)-1:0]   instr_addr_t;
    typedef logic [$clog2(SCRATCH_DEPTH)-1:0] scratch_addr_t;

    typedef struct packed {
        word_t paddr;
        logic  pwrite;
        logic  psel;
        logic  penable;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

endpackage

// ==== src/vmicro_core.sv ====
// 16-bit multicycle core top level
// Sequencer, register file, compare flags, branch and program counter
`timescale 1ns/10ps

module vmicro_core import isa_pkg::*, soc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        prog_we,
    input  instr_addr_t prog_addr,
    input  word_t       prog_data,
    output instr_addr_t pc,
    output apb_req_t    apb_req,
    input  apb_rsp_t    apb_rsp
);

    typedef enum logic [2:0] {ST_IF, ST_R1, ST_R2, ST_ME, ST_WB} state_e;

    state_e   state;
    word_t    instr, instr_rdata;
    decoded_t dec;
    word_t    regs [NUM_REGS];
    reg_sel_t rs;
    word_t    rs_data;
    word_t    rdd, rda, alu_c, cmp_flags;
    word_t    mem_addr, mem_rdata, wb_data;
    logic     mmu_req, mmu_busy, reg_we, take_branch;

    // Program load only while held in reset
    block_ram #(
        .DEPTH (INSTR_DEPTH)
    ) u_imem (
        .clk   (clk),
        .addr  ((reset && prog_we) ? prog_addr : pc),
        .wdata (prog_data),
        .we    (reset && prog_we),
        .rdata (instr_rdata)
    );

    instr_decoder u_dec (.instr(instr), .dec(dec));

    alu u_alu (.op(dec.alu_op), .a(rdd), .b(rda), .c(alu_c));

    core_mmu u_mmu (
        .clk     (clk),
        .reset   (reset),
        .req     (mmu_req),
        .busy    (mmu_busy),
        .addr    (mem_addr),
        .wdata   (rdd),
        .we      (dec.has_mem_we),
        .rdata   (mem_rdata),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // One read port, rd in R1 then ra in R2
    assign rs       = (state == ST_R1) ? dec.rd : dec.ra;
    assign rs_data  = regs[rs];
    assign mem_addr = alu_c + {{11{dec.simm5[4]}}, dec.simm5};
    assign wb_data  = dec.has_mem ? mem_rdata : alu_c;
    assign reg_we   = dec.has_we && (state == ST_WB);

    always_comb begin
        take_branch = 1'b0;
        if (dec.has_br) begin
            case (dec.imm8)
                BR_U:    take_branch = 1'b1;
                BR_E:    take_branch = cmp_flags[FLAG_Z];
                BR_L:    take_branch = cmp_flags[FLAG_L];
                default: take_branch = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IF;
            pc      <= '0;
            instr   <= '0;
            rdd     <= '0;
            rda     <= '0;
            mmu_req <= 1'b0;
        end else begin
            case (state)
                ST_IF: begin
                    instr <= instr_rdata;
                    state <= ST_R1;
                end
                ST_R1: begin
                    rdd   <= rs_data;
                    state <= ST_R2;
                end
                ST_R2: begin
                    if (dec.has_imm8) begin
                        rda <= word_t'(dec.imm8);
                    end else if (dec.has_imm4) begin
                        rda <= rs_data + word_t'(dec.imm4);
                    end else begin
                        rda <= rs_data;
                    end
                    if (dec.has_mem) begin
                        mmu_req <= 1'b1;
                        state   <= ST_ME;
                    end else begin
                        state <= ST_WB;
                    end
                    // Target is rd, pc saturates at the last word
                    if (take_branch) begin
                        pc <= rdd[$bits(instr_addr_t)-1:0];
                    end else if (pc != instr_addr_t'(INSTR_DEPTH - 1)) begin
                        pc <= pc + 1'b1;
                    end
                end
                ST_ME: begin
                    mmu_req <= 1'b0;
                    if (!mmu_busy) begin
                        state <= ST_WB;
                    end
                end
                default: state <= ST_IF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            cmp_flags <= '0;
        end else begin
            if (reg_we) begin
                regs[dec.rd] <= wb_data;
            end
            if (state == ST_WB && dec.has_cmp) begin
                cmp_flags <= alu_c;
            end
        end
    end

    // Write-back only once the memory unit has finished
    assert property (@(posedge clk) disable iff (reset)
        reg_we |-> !mmu_busy && ($past(state) inside {ST_R2, ST_ME}));

endmodule

// ==== verif/tb_core.sv ====
// Directed testbench for the 16-bit multicycle core
// Loads programs, plays the APB slave and checks bus traffic against a model
`timescale 1ns/10ps

module tb_core import isa_pkg::*, soc_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    // Per-test cycle limit well above the longest program run
    localparam int MAX_CYCLES   = 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        prog_we;
    instr_addr_t prog_addr;
    word_t       prog_data;
    instr_addr_t pc;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    integer   seed = 36222;
    int       run_cycles;
    string    cur_test;
    int       test_errors;
    int       total_errors;
    int       tests_run;
    int       tests_failed;
    int       apb_reads;
    word_t    prog_q [$];
    apb_req_t exp_log [$];
    apb_req_t wr_log [$];
    word_t    slave_mem [word_t];

    vmicro_core UUT (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    always #4 clk = ~clk;

    // Cycles since reset release
    always @(posedge clk) begin
        if (reset) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
        if (run_cycles >= MAX_CYCLES) begin
            $display("Timeout: test %s did not reach the last pc in %0d cycles",
                     cur_test, MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // Unwritten slave addresses read back a pattern of the whole address
    function automatic word_t fill_pattern(input word_t addr);
        return {addr[7:0], addr[15:8]} ^ 16'hC35A;
    endfunction

    function automatic word_t read_slave(input word_t addr);
        if (slave_mem.exists(addr)) begin
            return slave_mem[addr];
        end
        return fill_pattern(addr);
    endfunction

    task automatic serve_transfer;
        int waits;
        while ((apb_req.psel && apb_req.penable) !== 1'b1) begin
            @(negedge clk);
        end
        waits = $unsigned($random(seed)) % 4;
        repeat (waits) @(negedge clk);
        apb_rsp.pready = 1'b1;
        if (apb_req.pwrite) begin
            wr_log.push_back(apb_req);
            slave_mem[apb_req.paddr] = apb_req.pwdata;
        end else begin
            apb_reads++;
            apb_rsp.prdata = read_slave(apb_req.paddr);
        end
        @(negedge clk);
        apb_rsp.pready = 1'b0;
        apb_rsp.prdata = '0;
    endtask

    initial begin
        apb_rsp = '0;
        forever serve_transfer();
    end

    function automatic void emit_rr(input opcode_e op, input int rd, input int ra,
                                    input logic [4:0] low);
        prog_q.push_back({op, reg_sel_t'(rd), reg_sel_t'(ra), low});
    endfunction

    function automatic void emit_ri(input opcode_e op, input int rd, input int imm);
        prog_q.push_back({op, reg_sel_t'(rd), 8'(imm)});
    endfunction

    function automatic apb_req_t apb_write(input word_t addr, input word_t data);
        apb_req_t r;
        r.paddr   = addr;
        r.pwrite  = 1'b1;
        r.psel    = 1'b1;
        r.penable = 1'b1;
        r.pwdata  = data;
        return r;
    endfunction

    // Branch rule on the flags of the last compare of a and b
    function automatic logic branch_taken(input logic [7:0] cond, input int a, input int b);
        if (cond == BR_E) begin
            return a == b;
        end
        if (cond == BR_L) begin
            return a < b;
        end
        return cond == BR_U;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string what, input instr_addr_t exp, input instr_addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_apb(input string what, input apb_req_t exp, input apb_req_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h/%h w%b s%b e%b, actual %h/%h w%b s%b e%b",
                     cur_test, what, exp.paddr, exp.pwdata, exp.pwrite, exp.psel, exp.penable,
                     act.paddr, act.pwdata, act.pwrite, act.psel, act.penable);
            test_errors++;
        end
    endtask

    task automatic check_writes;
        int i;
        if (wr_log.size() != exp_log.size()) begin
            $display("%s: expected %0d APB writes but the slave saw %0d",
                     cur_test, exp_log.size(), wr_log.size());
            test_errors++;
        end else begin
            for (i = 0; i < exp_log.size(); i++) begin
                check_apb($sformatf("write %0d", i), exp_log[i], wr_log[i]);
            end
        end
    endtask

    task automatic check_reads(input int n);
        if (apb_reads != n) begin
            $display("%s: expected %0d APB reads but the slave saw %0d", cur_test, n, apb_reads);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        prog_q.delete();
        exp_log.delete();
    endtask

    task automatic end_test;
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    // Called on a falling edge; pads with NOP and fills the whole memory
    task automatic load_program;
        int i;
        reset = 1'b1;
        if (prog_q.size() > INSTR_DEPTH) begin
            $display("%s: program has %0d words, memory holds %0d",
                     cur_test, prog_q.size(), INSTR_DEPTH);
            test_errors++;
        end
        while (prog_q.size() < INSTR_DEPTH) begin
            prog_q.push_back(16'h0000);
        end
        wr_log.delete();
        slave_mem.delete();
        apb_reads = 0;
        for (i = 0; i < INSTR_DEPTH; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = instr_addr_t'(i);
            prog_data = prog_q[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    // Done once pc saturates well past the last real instruction
    task automatic wait_program_end;
        while (pc !== instr_addr_t'(INSTR_DEPTH - 1)) begin
            @(negedge clk);
        end
    endtask

    task automatic run_program;
        load_program();
        wait_program_end();
    endtask

    task automatic test_reset;
        start_test("reset");
        repeat (2) @(negedge clk);
        check_apb("bus in reset", '0, apb_req);
        check_addr("pc in reset", '0, pc);
        load_program();
        @(negedge clk);
        check_apb("bus after reset", '0, apb_req);
        check_addr("pc after reset", '0, pc);
        wait_program_end();
        // Two more NOPs must leave pc on the last word
        repeat (8) @(negedge clk);
        check_addr("pc saturated", instr_addr_t'(INSTR_DEPTH - 1), pc);
        check_writes();
        check_reads(0);
        end_test();
    endtask

    task automatic test_single_store;
        start_test("single_store");
        emit_ri(OP_MOVI, 1, 'h5C);
        emit_ri(OP_MOVI, 7, 'h80);
        emit_rr(OP_SW, 1, 7, 5'd0);
        exp_log.push_back(apb_write(16'h0080, 16'h005C));
        run_program();
        check_writes();
        check_reads(0);
        end_test();
    endtask

    // MOV r3 from r1, apply the operation, store r3 to 0x80 plus slot
    function automatic void alu_case(input opcode_e op, input logic [4:0] sub, input int src,
                                     input int slot, input word_t exp_val);
        emit_rr(OP_MOV, 3, 1, 5'd0);
        emit_rr(op, 3, src, sub);
        emit_rr(OP_SW, 3, 7, 5'(slot));
        exp_log.push_back(apb_write(16'h0080 + 16'(slot), exp_val));
    endfunction

    task automatic test_alu;
        int    a;
        int    b;
        int    s;
        int    imm;
        word_t wa;
        word_t wb;
        start_test("alu_ops");
        a   = $unsigned($random(seed)) % 256;
        b   = $unsigned($random(seed)) % 256;
        s   = 1 + $unsigned($random(seed)) % 7;
        imm = $unsigned($random(seed)) % 16;
        wa  = 16'(a);
        wb  = 16'(b);
        emit_ri(OP_MOVI, 1, a);
        emit_ri(OP_MOVI, 2, b);
        emit_ri(OP_MOVI, 4, s);
        emit_ri(OP_MOVI, 7, 'h80);
        alu_case(OP_BIT, BIT_OR, 2, 0, wa | wb);
        alu_case(OP_BIT, BIT_XOR, 2, 1, wa ^ wb);
        alu_case(OP_BIT, BIT_AND, 2, 2, wa & wb);
        alu_case(OP_BIT, BIT_NOT, 2, 3, ~wb);
        alu_case(OP_BIT, BIT_LSHFT, 4, 4, wa << s);
        alu_case(OP_BIT, BIT_RSHFT, 4, 5, wa >> s);
        alu_case(OP_ARITH_U, ARITH_UADD, 2, 6, wa + wb);
        alu_case(OP_ARITH_U, ARITH_USUB, 2, 7, wa - wb);
        // Immediate add takes rd plus ra plus imm4
        alu_case(OP_ARITH_U, {1'b0, 4'(imm)}, 2, 8, wa + (wb + 16'(imm)));
        run_program();
        check_writes();
        check_reads(0);
        end_test();
    endtask

    task automatic test_scratch;
        start_test("scratch_memory");
        emit_ri(OP_MOVI, 1, 'hA7);
        emit_ri(OP_MOVI, 2, 'h14);
        emit_ri(OP_MOVI, 7, 'h80);
        // Scratch word 0x13 through a negative offset
        emit_rr(OP_SW, 1, 2, 5'(-1));
        // Clear r1 so only the load can restore it
        emit_ri(OP_MOVI, 1, 0);
        emit_rr(OP_LW, 1, 2, 5'(-1));
        emit_rr(OP_SW, 1, 7, 5'd5);
        exp_log.push_back(apb_write(16'h0085, 16'h00A7));
        run_program();
        check_writes();
        check_reads(0);
        end_test();
    endtask

    task automatic test_apb_load;
        start_test("apb_load");
        emit_ri(OP_MOVI, 2, 'hC0);
        emit_ri(OP_MOVI, 7, 'h80);
        emit_rr(OP_LW, 3, 2, 5'd2);
        emit_rr(OP_LW, 4, 2, 5'(-4));
        emit_rr(OP_SW, 3, 7, 5'd0);
        emit_rr(OP_SW, 4, 7, 5'd1);
        exp_log.push_back(apb_write(16'h0080, fill_pattern(16'h00C2)));
        exp_log.push_back(apb_write(16'h0081, fill_pattern(16'h00BC)));
        run_program();
        check_writes();
        check_reads(2);
        check_word("echo of load", read_slave(16'h00C2), read_slave(16'h0080));
        end_test();
    endtask

    // Fall-through marker 0x10+k is skipped when taken and target marker 0x20+k always lands
    function automatic void branch_step(input logic [7:0] cond, input int k,
                                        input int ca, input int cb);
        int fix;
        fix = prog_q.size();
        emit_ri(OP_MOVI, 5, 0);
        emit_ri(OP_BR, 5, int'(cond));
        emit_ri(OP_MOVI, 6, 'h10 + k);
        emit_rr(OP_SW, 6, 7, 5'(k));
        prog_q[fix] = {OP_MOVI, 3'd5, 8'(prog_q.size())};
        emit_ri(OP_MOVI, 6, 'h20 + k);
        emit_rr(OP_SW, 6, 7, 5'(k));
        if (!branch_taken(cond, ca, cb)) begin
            exp_log.push_back(apb_write(16'h0090 + 16'(k), 16'h0010 + 16'(k)));
        end
        exp_log.push_back(apb_write(16'h0090 + 16'(k), 16'h0020 + 16'(k)));
    endfunction

    task automatic test_branch;
        start_test("compare_branch");
        emit_ri(OP_MOVI, 7, 'h90);
        emit_ri(OP_MOVI, 1, 5);
        emit_ri(OP_MOVI, 2, 5);
        emit_ri(OP_MOVI, 3, 9);
        emit_rr(OP_CMP, 1, 2, 5'd0);
        branch_step(BR_E, 0, 5, 5);
        branch_step(BR_L, 1, 5, 5);
        emit_rr(OP_CMP, 1, 3, 5'd0);
        branch_step(BR_L, 2, 5, 9);
        branch_step(BR_E, 3, 5, 9);
        emit_rr(OP_CMP, 3, 1, 5'd0);
        branch_step(BR_L, 4, 9, 5);
        branch_step(BR_U, 5, 9, 5);
        run_program();
        check_writes();
        end_test();
    endtask

    initial begin
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        test_reset();
        test_single_store();
        test_alu();
        test_scratch();
        test_apb_load();
        test_branch();
        $display("%0d tests run, %0d with errors, %0d failed checks",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
